//--- list.f
+incdir+src
src/cdb_pkg.sv
src/cdb_one_entry.sv
src/cdb_result_slots.sv
src/cdb_ctrl.sv
src/cdb_flush_timer.sv
src/cdb_top.sv
tests/tb_cdb.sv

//--- run.sh
#!/bin/sh
# Build and run the CDB completion stage testbench with Verilator.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "Cannot enter the project directory"
	exit 1
fi

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f list.f --top-module tb_cdb -Mdir obj_dir -o sim_cdb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_cdb 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -q "^SIMULATION PASSED$"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- src/cdb_config.svh
/*
 * CDB completion stage configuration.
 * Register file, ROB and result sizes plus the squash refill period.
 */
`ifndef CDB_CONFIG_SVH
`define CDB_CONFIG_SVH

`define PRF_SIZE 64 // Physical registers.
`define ROB_SIZE 32 // Reorder buffer entries.
`define CDB_XLEN 64 // Result word width.

// Bus stays blocked this many cycles after the squash cycle.
`define FLUSH_CYCLES 3

// mem1, mem2, mult1, mult2, adder1, adder2.
`define NUM_FU 6

`endif

//--- src/cdb_ctrl.sv
/*
 * CDB controller.
 * Run/flush FSM and fixed-priority grant, mem1 highest down to adder2.
 */
`include "cdb_config.svh"

module cdb_ctrl (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                squash,
	input  cdb_pkg::fu_onehot_t slot_full,
	input  logic                timer_done,   // Last blocked cycle.
	output cdb_pkg::fu_onehot_t fu_select,
	output logic                timer_start
);
	import cdb_pkg::*;

	cdb_state_t state_q;
	cdb_state_t state_d;

	always_comb
	begin
		state_d = state_q;
		case (state_q)
		CDB_RUN:
			if (squash)
				state_d = CDB_FLUSH;
		CDB_FLUSH:
			if (timer_done)
				state_d = CDB_RUN; // Squash here just clears slots again.
		default:
			state_d = CDB_RUN;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			state_q <= CDB_RUN;
		else
			state_q <= state_d;
	end

	assign timer_start = squash && (state_q == CDB_RUN); // One pulse per flush.

	// Priority pick. Later, higher bits overwrite lower ones.
	always_comb
	begin
		fu_select = '0;
		if (state_q == CDB_RUN && !squash)
		begin
			for (int i = 0; i < `NUM_FU; i++)
			begin
				if (slot_full[i])
					fu_select = fu_onehot_t'(1) << i;
			end
		end
	end

	// Timer hands the bus back exactly one refill period after the squash cycle.
	a_flush_length: assert property (@(posedge clk) disable iff (!rst_n)
		timer_start |-> ##(`FLUSH_CYCLES + 1) state_q == CDB_RUN);

endmodule

//--- src/cdb_flush_timer.sv
/*
 * Refill countdown after a squash.
 * Loads the refill period on start and flags the last blocked cycle.
 */
`include "cdb_config.svh"

module cdb_flush_timer (
	input  logic clk,
	input  logic rst_n,
	input  logic timer_start,
	output logic timer_done
);
	localparam int CNT_W = $clog2(`FLUSH_CYCLES + 1);

	logic [CNT_W-1:0] count_q; // Blocked cycles still to go.

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			count_q <= '0;
		else if (timer_start)
			count_q <= CNT_W'(`FLUSH_CYCLES);
		else if (count_q != '0)
			count_q <= count_q - 1'b1; // Holds at zero when idle.
	end

	// Count hits zero at this edge.
	assign timer_done = (count_q == CNT_W'(1));

	// No restart while a refill is still running.
	a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
		timer_start |-> count_q == '0);

endmodule

//--- src/cdb_one_entry.sv
/*
 * CDB output mux.
 * Routes the selected unit's held result, tag and ROB index onto the bus.
 */
`include "cdb_config.svh"

module cdb_one_entry (
	input  cdb_pkg::fu_onehot_t fu_select,      // One-hot grant, or zero.

	input  cdb_pkg::cdb_data_t  mem1_result_in,
	input  cdb_pkg::prf_tag_t   mem1_dest_reg_idx,
	input  cdb_pkg::rob_idx_t   mem1_rob_idx,
	input  cdb_pkg::cdb_data_t  mem2_result_in,
	input  cdb_pkg::prf_tag_t   mem2_dest_reg_idx,
	input  cdb_pkg::rob_idx_t   mem2_rob_idx,
	input  cdb_pkg::cdb_data_t  mult1_result_in,
	input  cdb_pkg::prf_tag_t   mult1_dest_reg_idx,
	input  cdb_pkg::rob_idx_t   mult1_rob_idx,
	input  cdb_pkg::cdb_data_t  mult2_result_in,
	input  cdb_pkg::prf_tag_t   mult2_dest_reg_idx,
	input  cdb_pkg::rob_idx_t   mult2_rob_idx,
	input  cdb_pkg::cdb_data_t  adder1_result_in,
	input  cdb_pkg::prf_tag_t   adder1_dest_reg_idx,
	input  cdb_pkg::rob_idx_t   adder1_rob_idx,
	input  cdb_pkg::cdb_data_t  adder2_result_in,
	input  cdb_pkg::prf_tag_t   adder2_dest_reg_idx,
	input  cdb_pkg::rob_idx_t   adder2_rob_idx,

	output logic                cdb_valid,
	output cdb_pkg::prf_tag_t   cdb_tag,
	output cdb_pkg::cdb_data_t  cdb_out,
	output cdb_pkg::rob_idx_t   cdb_rob_idx
);
	import cdb_pkg::*;

	// Select codes, mem1 in the top bit.
	localparam fu_onehot_t SEL_MEM1   = fu_onehot_t'(1) << (`NUM_FU - 1);
	localparam fu_onehot_t SEL_MEM2   = fu_onehot_t'(1) << (`NUM_FU - 2);
	localparam fu_onehot_t SEL_MULT1  = fu_onehot_t'(1) << (`NUM_FU - 3);
	localparam fu_onehot_t SEL_MULT2  = fu_onehot_t'(1) << (`NUM_FU - 4);
	localparam fu_onehot_t SEL_ADDER1 = fu_onehot_t'(1) << (`NUM_FU - 5);
	localparam fu_onehot_t SEL_ADDER2 = fu_onehot_t'(1) << (`NUM_FU - 6);

	always_comb
	begin
		cdb_valid   = 1'b1; // Overridden by default arm.
		cdb_tag     = '0;
		cdb_out     = '0;
		cdb_rob_idx = '0;
		case (fu_select)
		SEL_MEM1:
			begin
				cdb_tag     = mem1_dest_reg_idx;
				cdb_out     = mem1_result_in;
				cdb_rob_idx = mem1_rob_idx;
			end
		SEL_MEM2:
			begin
				cdb_tag     = mem2_dest_reg_idx;
				cdb_out     = mem2_result_in;
				cdb_rob_idx = mem2_rob_idx;
			end
		SEL_MULT1:
			begin
				cdb_tag     = mult1_dest_reg_idx;
				cdb_out     = mult1_result_in;
				cdb_rob_idx = mult1_rob_idx;
			end
		SEL_MULT2:
			begin
				cdb_tag     = mult2_dest_reg_idx;
				cdb_out     = mult2_result_in;
				cdb_rob_idx = mult2_rob_idx;
			end
		SEL_ADDER1:
			begin
				cdb_tag     = adder1_dest_reg_idx;
				cdb_out     = adder1_result_in;
				cdb_rob_idx = adder1_rob_idx;
			end
		SEL_ADDER2:
			begin
				cdb_tag     = adder2_dest_reg_idx;
				cdb_out     = adder2_result_in;
				cdb_rob_idx = adder2_rob_idx;
			end
		default:
			cdb_valid = 1'b0; // Idle or illegal select, fields stay zero.
		endcase
	end

	// Controller must never grant two units at once.
	always_comb
	begin
		a_select_onehot0: assert ($onehot0(fu_select));
	end

endmodule

//--- src/cdb_pkg.sv
/*
 * CDB types shared by the completion stage.
 * Bus fields, the per-unit one-hot vector and the controller states.
 */
`include "cdb_config.svh"

package cdb_pkg;

	// Broadcast payload fields.
	typedef logic [`CDB_XLEN-1:0] cdb_data_t;
	typedef logic [$clog2(`PRF_SIZE)-1:0] prf_tag_t; // Destination physical register.
	typedef logic [$clog2(`ROB_SIZE)-1:0] rob_idx_t; // Owning ROB entry.

	// One bit per unit.
	// Bit 5 is mem1, bit 0 is adder2, so higher bit means higher priority.
	typedef logic [`NUM_FU-1:0] fu_onehot_t;

	// Controller states.
	typedef enum logic
	{
		CDB_RUN,   // Normal arbitration.
		CDB_FLUSH  // Bus blocked during refill.
	} cdb_state_t;

endpackage

//--- src/cdb_result_slots.sv
/*
 * Per-unit result holding slots.
 * Capture a unit's fields on done, release on grant, drop all on squash.
 */
`include "cdb_config.svh"

module cdb_result_slots (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                squash,

	input  logic                mem1_done,
	input  cdb_pkg::cdb_data_t  mem1_result,
	input  cdb_pkg::prf_tag_t   mem1_tag,
	input  cdb_pkg::rob_idx_t   mem1_rob_idx,
	input  logic                mem2_done,
	input  cdb_pkg::cdb_data_t  mem2_result,
	input  cdb_pkg::prf_tag_t   mem2_tag,
	input  cdb_pkg::rob_idx_t   mem2_rob_idx,
	input  logic                mult1_done,
	input  cdb_pkg::cdb_data_t  mult1_result,
	input  cdb_pkg::prf_tag_t   mult1_tag,
	input  cdb_pkg::rob_idx_t   mult1_rob_idx,
	input  logic                mult2_done,
	input  cdb_pkg::cdb_data_t  mult2_result,
	input  cdb_pkg::prf_tag_t   mult2_tag,
	input  cdb_pkg::rob_idx_t   mult2_rob_idx,
	input  logic                adder1_done,
	input  cdb_pkg::cdb_data_t  adder1_result,
	input  cdb_pkg::prf_tag_t   adder1_tag,
	input  cdb_pkg::rob_idx_t   adder1_rob_idx,
	input  logic                adder2_done,
	input  cdb_pkg::cdb_data_t  adder2_result,
	input  cdb_pkg::prf_tag_t   adder2_tag,
	input  cdb_pkg::rob_idx_t   adder2_rob_idx,

	input  cdb_pkg::fu_onehot_t grant,          // Slot being broadcast this cycle.
	output cdb_pkg::fu_onehot_t slot_full,

	output cdb_pkg::cdb_data_t  mem1_held_result,
	output cdb_pkg::prf_tag_t   mem1_held_tag,
	output cdb_pkg::rob_idx_t   mem1_held_rob_idx,
	output cdb_pkg::cdb_data_t  mem2_held_result,
	output cdb_pkg::prf_tag_t   mem2_held_tag,
	output cdb_pkg::rob_idx_t   mem2_held_rob_idx,
	output cdb_pkg::cdb_data_t  mult1_held_result,
	output cdb_pkg::prf_tag_t   mult1_held_tag,
	output cdb_pkg::rob_idx_t   mult1_held_rob_idx,
	output cdb_pkg::cdb_data_t  mult2_held_result,
	output cdb_pkg::prf_tag_t   mult2_held_tag,
	output cdb_pkg::rob_idx_t   mult2_held_rob_idx,
	output cdb_pkg::cdb_data_t  adder1_held_result,
	output cdb_pkg::prf_tag_t   adder1_held_tag,
	output cdb_pkg::rob_idx_t   adder1_held_rob_idx,
	output cdb_pkg::cdb_data_t  adder2_held_result,
	output cdb_pkg::prf_tag_t   adder2_held_tag,
	output cdb_pkg::rob_idx_t   adder2_held_rob_idx
);
	import cdb_pkg::*;

	fu_onehot_t done_vec;
	fu_onehot_t full_q;
	cdb_data_t  res_in [`NUM_FU];  // Indexed by select bit.
	prf_tag_t   tag_in [`NUM_FU];
	rob_idx_t   rob_in [`NUM_FU];
	cdb_data_t  res_q  [`NUM_FU];
	prf_tag_t   tag_q  [`NUM_FU];
	rob_idx_t   rob_q  [`NUM_FU];

	assign done_vec = {mem1_done, mem2_done, mult1_done, mult2_done, adder1_done, adder2_done};

	assign res_in[5] = mem1_result;
	assign tag_in[5] = mem1_tag;
	assign rob_in[5] = mem1_rob_idx;
	assign res_in[4] = mem2_result;
	assign tag_in[4] = mem2_tag;
	assign rob_in[4] = mem2_rob_idx;
	assign res_in[3] = mult1_result;
	assign tag_in[3] = mult1_tag;
	assign rob_in[3] = mult1_rob_idx;
	assign res_in[2] = mult2_result;
	assign tag_in[2] = mult2_tag;
	assign rob_in[2] = mult2_rob_idx;
	assign res_in[1] = adder1_result;
	assign tag_in[1] = adder1_tag;
	assign rob_in[1] = adder1_rob_idx;
	assign res_in[0] = adder2_result;
	assign tag_in[0] = adder2_tag;
	assign rob_in[0] = adder2_rob_idx;

	// Occupancy. Squash beats done, done beats grant.
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			full_q <= '0;
		else if (squash)
			full_q <= '0; // Late done in squash cycle is lost.
		else
			full_q <= done_vec | (full_q & ~grant);
	end

	// Payload only.
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < `NUM_FU; i++)
		begin
			if (done_vec[i] && !squash)
			begin
				res_q[i] <= res_in[i];
				tag_q[i] <= tag_in[i];
				rob_q[i] <= rob_in[i];
			end
		end
	end

	assign slot_full = full_q; // Doubles as unit busy.

	assign mem1_held_result    = res_q[5];
	assign mem1_held_tag       = tag_q[5];
	assign mem1_held_rob_idx   = rob_q[5];
	assign mem2_held_result    = res_q[4];
	assign mem2_held_tag       = tag_q[4];
	assign mem2_held_rob_idx   = rob_q[4];
	assign mult1_held_result   = res_q[3];
	assign mult1_held_tag      = tag_q[3];
	assign mult1_held_rob_idx  = rob_q[3];
	assign mult2_held_result   = res_q[2];
	assign mult2_held_tag      = tag_q[2];
	assign mult2_held_rob_idx  = rob_q[2];
	assign adder1_held_result  = res_q[1];
	assign adder1_held_tag     = tag_q[1];
	assign adder1_held_rob_idx = rob_q[1];
	assign adder2_held_result  = res_q[0];
	assign adder2_held_tag     = tag_q[0];
	assign adder2_held_rob_idx = rob_q[0];

	// Units honour busy. A result may only land in a slot that is free or leaving.
	a_done_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
		(done_vec & full_q & ~grant) == '0);

	// Controller only grants slots that hold something.
	a_grant_full: assert property (@(posedge clk) disable iff (!rst_n)
		(grant & ~full_q) == '0);

endmodule

//--- src/cdb_top.sv
/*
 * CDB completion stage top.
 * Result slots, controller, refill timer and bus mux.
 */
module cdb_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                squash,

	input  logic                mem1_done,
	input  cdb_pkg::cdb_data_t  mem1_result,
	input  cdb_pkg::prf_tag_t   mem1_tag,
	input  cdb_pkg::rob_idx_t   mem1_rob_idx,
	input  logic                mem2_done,
	input  cdb_pkg::cdb_data_t  mem2_result,
	input  cdb_pkg::prf_tag_t   mem2_tag,
	input  cdb_pkg::rob_idx_t   mem2_rob_idx,
	input  logic                mult1_done,
	input  cdb_pkg::cdb_data_t  mult1_result,
	input  cdb_pkg::prf_tag_t   mult1_tag,
	input  cdb_pkg::rob_idx_t   mult1_rob_idx,
	input  logic                mult2_done,
	input  cdb_pkg::cdb_data_t  mult2_result,
	input  cdb_pkg::prf_tag_t   mult2_tag,
	input  cdb_pkg::rob_idx_t   mult2_rob_idx,
	input  logic                adder1_done,
	input  cdb_pkg::cdb_data_t  adder1_result,
	input  cdb_pkg::prf_tag_t   adder1_tag,
	input  cdb_pkg::rob_idx_t   adder1_rob_idx,
	input  logic                adder2_done,
	input  cdb_pkg::cdb_data_t  adder2_result,
	input  cdb_pkg::prf_tag_t   adder2_tag,
	input  cdb_pkg::rob_idx_t   adder2_rob_idx,

	output cdb_pkg::fu_onehot_t fu_busy,      // Unit may not signal done while set.
	output logic                cdb_valid,
	output cdb_pkg::prf_tag_t   cdb_tag,
	output cdb_pkg::cdb_data_t  cdb_out,
	output cdb_pkg::rob_idx_t   cdb_rob_idx
);
	import cdb_pkg::*;

	fu_onehot_t slot_full;
	fu_onehot_t fu_select;
	logic       timer_start;
	logic       timer_done;

	// Held slot contents, named to match the slot ports.
	cdb_data_t  mem1_held_result;
	prf_tag_t   mem1_held_tag;
	rob_idx_t   mem1_held_rob_idx;
	cdb_data_t  mem2_held_result;
	prf_tag_t   mem2_held_tag;
	rob_idx_t   mem2_held_rob_idx;
	cdb_data_t  mult1_held_result;
	prf_tag_t   mult1_held_tag;
	rob_idx_t   mult1_held_rob_idx;
	cdb_data_t  mult2_held_result;
	prf_tag_t   mult2_held_tag;
	rob_idx_t   mult2_held_rob_idx;
	cdb_data_t  adder1_held_result;
	prf_tag_t   adder1_held_tag;
	rob_idx_t   adder1_held_rob_idx;
	cdb_data_t  adder2_held_result;
	prf_tag_t   adder2_held_tag;
	rob_idx_t   adder2_held_rob_idx;

	cdb_result_slots u_slots (
		.grant (fu_select), // Granted slot empties after broadcast.
		.*
	);

	cdb_ctrl u_ctrl (.*);

	cdb_flush_timer u_timer (.*);

	cdb_one_entry u_bus (
		.fu_select           (fu_select),
		.mem1_result_in      (mem1_held_result),
		.mem1_dest_reg_idx   (mem1_held_tag),
		.mem1_rob_idx        (mem1_held_rob_idx),
		.mem2_result_in      (mem2_held_result),
		.mem2_dest_reg_idx   (mem2_held_tag),
		.mem2_rob_idx        (mem2_held_rob_idx),
		.mult1_result_in     (mult1_held_result),
		.mult1_dest_reg_idx  (mult1_held_tag),
		.mult1_rob_idx       (mult1_held_rob_idx),
		.mult2_result_in     (mult2_held_result),
		.mult2_dest_reg_idx  (mult2_held_tag),
		.mult2_rob_idx       (mult2_held_rob_idx),
		.adder1_result_in    (adder1_held_result),
		.adder1_dest_reg_idx (adder1_held_tag),
		.adder1_rob_idx      (adder1_held_rob_idx),
		.adder2_result_in    (adder2_held_result),
		.adder2_dest_reg_idx (adder2_held_tag),
		.adder2_rob_idx      (adder2_held_rob_idx),
		.cdb_valid           (cdb_valid),
		.cdb_tag             (cdb_tag),
		.cdb_out             (cdb_out),
		.cdb_rob_idx         (cdb_rob_idx)
	);

	assign fu_busy = slot_full; // Full slot means unit still waiting.

endmodule

//--- tests/tb_cdb.sv
/*
 * Testbench for the CDB completion stage.
 * Table-driven done and squash stimulus, checked against a slot reference model.
 */
`include "cdb_config.svh"

module tb_cdb;
	timeunit 1ns;
	timeprecision 100ps;

	import cdb_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int NUM_ROWS   = 31;

	// Unit masks, mem1 in bit 5.
	localparam fu_onehot_t NONE  = 6'b000000;
	localparam fu_onehot_t MEM1  = 6'b100000;
	localparam fu_onehot_t MEM2  = 6'b010000;
	localparam fu_onehot_t MULT1 = 6'b001000;
	localparam fu_onehot_t MULT2 = 6'b000100;
	localparam fu_onehot_t ADD1  = 6'b000010;
	localparam fu_onehot_t ADD2  = 6'b000001;
	localparam fu_onehot_t ALL   = 6'b111111;

	typedef struct packed
	{
		logic       squash;
		fu_onehot_t done;      // Units pulsing done this cycle.
		logic       exp_valid;
		fu_onehot_t exp_unit;  // Expected winner, one-hot or zero.
	} row_t;

	logic       clk;
	logic       rst_n;
	logic       squash;
	fu_onehot_t done_in;       // Indexed like fu_onehot_t.
	cdb_data_t  res_in [`NUM_FU];
	prf_tag_t   tag_in [`NUM_FU];
	rob_idx_t   rob_in [`NUM_FU];

	fu_onehot_t fu_busy;
	logic       cdb_valid;
	prf_tag_t   cdb_tag;
	cdb_data_t  cdb_out;
	rob_idx_t   cdb_rob_idx;

	// Reference model of the slots.
	fu_onehot_t m_full;
	cdb_data_t  m_res [`NUM_FU];
	prf_tag_t   m_tag [`NUM_FU];
	rob_idx_t   m_rob [`NUM_FU];
	int         m_block;       // Blocked bus cycles still ahead.

	row_t   rows [NUM_ROWS];
	integer seed;

	cdb_top u_dut (
		.clk            (clk),
		.rst_n          (rst_n),
		.squash         (squash),
		.mem1_done      (done_in[5]),
		.mem1_result    (res_in[5]),
		.mem1_tag       (tag_in[5]),
		.mem1_rob_idx   (rob_in[5]),
		.mem2_done      (done_in[4]),
		.mem2_result    (res_in[4]),
		.mem2_tag       (tag_in[4]),
		.mem2_rob_idx   (rob_in[4]),
		.mult1_done     (done_in[3]),
		.mult1_result   (res_in[3]),
		.mult1_tag      (tag_in[3]),
		.mult1_rob_idx  (rob_in[3]),
		.mult2_done     (done_in[2]),
		.mult2_result   (res_in[2]),
		.mult2_tag      (tag_in[2]),
		.mult2_rob_idx  (rob_in[2]),
		.adder1_done    (done_in[1]),
		.adder1_result  (res_in[1]),
		.adder1_tag     (tag_in[1]),
		.adder1_rob_idx (rob_in[1]),
		.adder2_done    (done_in[0]),
		.adder2_result  (res_in[0]),
		.adder2_tag     (tag_in[0]),
		.adder2_rob_idx (rob_in[0]),
		.fu_busy        (fu_busy),
		.cdb_valid      (cdb_valid),
		.cdb_tag        (cdb_tag),
		.cdb_out        (cdb_out),
		.cdb_rob_idx    (cdb_rob_idx)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Run length is reset plus one cycle per row, with margin.
	initial
	begin
		#((NUM_ROWS + 20) * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d ns.", (NUM_ROWS + 20) * CLK_PERIOD);
		$display("SIMULATION FAILED");
		$fatal(1, "Watchdog expired.");
	end

	// Columns: squash, done mask, bus valid, winning unit.
	task automatic load_table();
		rows[0]  = '{1'b0, NONE,  1'b0, NONE};  // Idle after reset.
		rows[1]  = '{1'b0, ADD2,  1'b0, NONE};
		rows[2]  = '{1'b0, NONE,  1'b1, ADD2};  // Next cycle on the bus.
		rows[3]  = '{1'b0, NONE,  1'b0, NONE};  // Busy dropped.
		rows[4]  = '{1'b0, ALL,   1'b0, NONE};  // All six at once.
		rows[5]  = '{1'b0, NONE,  1'b1, MEM1};
		rows[6]  = '{1'b0, NONE,  1'b1, MEM2};
		rows[7]  = '{1'b0, NONE,  1'b1, MULT1};
		rows[8]  = '{1'b0, NONE,  1'b1, MULT2};
		rows[9]  = '{1'b0, NONE,  1'b1, ADD1};
		rows[10] = '{1'b0, NONE,  1'b1, ADD2};
		rows[11] = '{1'b0, NONE,  1'b0, NONE};
		rows[12] = '{1'b0, ADD1 | ADD2, 1'b0, NONE};
		rows[13] = '{1'b0, MULT1, 1'b1, ADD1};  // adder2 waits.
		rows[14] = '{1'b0, MEM2,  1'b1, MULT1}; // Higher done overtakes adder2.
		rows[15] = '{1'b0, NONE,  1'b1, MEM2};
		rows[16] = '{1'b0, NONE,  1'b1, ADD2};
		rows[17] = '{1'b0, NONE,  1'b0, NONE};
		rows[18] = '{1'b0, MEM1 | MEM2 | MULT1 | MULT2, 1'b0, NONE};
		rows[19] = '{1'b1, ADD1,  1'b0, NONE};  // Squash, adder1 dropped.
		rows[20] = '{1'b0, NONE,  1'b0, NONE};
		rows[21] = '{1'b0, NONE,  1'b0, NONE};
		rows[22] = '{1'b0, NONE,  1'b0, NONE};
		rows[23] = '{1'b0, NONE,  1'b0, NONE};  // Run again, nothing left.
		rows[24] = '{1'b0, MEM1 | MEM2, 1'b0, NONE};
		rows[25] = '{1'b1, NONE,  1'b0, NONE};
		rows[26] = '{1'b0, MULT2, 1'b0, NONE};  // Done inside the flush.
		rows[27] = '{1'b0, NONE,  1'b0, NONE};
		rows[28] = '{1'b0, NONE,  1'b0, NONE};
		rows[29] = '{1'b0, NONE,  1'b1, MULT2}; // First cycle after flush.
		rows[30] = '{1'b0, NONE,  1'b0, NONE};
	endtask

	// Highest-priority full slot, -1 when none.
	function automatic int top_slot(input fu_onehot_t full);
		int idx;
		idx = -1;
		for (int i = `NUM_FU - 1; i >= 0; i--)
		begin
			if (full[i] && idx < 0)
				idx = i;
		end
		return idx;
	endfunction

	task automatic drive_row(input row_t row);
		squash  = row.squash;
		done_in = row.done;
		for (int i = 0; i < `NUM_FU; i++)
		begin
			if (row.done[i])
			begin
				res_in[i] = {$random(seed), $random(seed)};
				tag_in[i] = prf_tag_t'($random(seed));
				rob_in[i] = rob_idx_t'($random(seed));
			end
		end
	endtask

	task automatic confirm_table_row(input int row, input int idx);
		fu_onehot_t model_sel;
		model_sel = (idx < 0) ? NONE : fu_onehot_t'(1) << idx;
		if (model_sel !== rows[row].exp_unit || rows[row].exp_valid !== (idx >= 0))
		begin
			$display("Table row %0d expects valid %b unit %b but the model picks %b.",
				row, rows[row].exp_valid, rows[row].exp_unit, model_sel);
			$display("SIMULATION FAILED");
			$fatal(1, "Stimulus table and reference model disagree.");
		end
	endtask

	task automatic check_bus(input logic exp_valid, input prf_tag_t exp_tag,
		input cdb_data_t exp_data, input rob_idx_t exp_rob, input int row);
		if (cdb_valid !== exp_valid || cdb_tag !== exp_tag || cdb_out !== exp_data
			|| cdb_rob_idx !== exp_rob)
		begin
			$display("Mismatch at %0t: row %0d bus valid=%b tag=%0d rob=%0d data=%h",
				$time, row, cdb_valid, cdb_tag, cdb_rob_idx, cdb_out);
			$display("  expected valid=%b tag=%0d rob=%0d data=%h",
				exp_valid, exp_tag, exp_rob, exp_data);
			$display("SIMULATION FAILED");
			$fatal(1, "Bus check failed.");
		end
	endtask

	task automatic check_busy(input fu_onehot_t exp_busy, input int row);
		if (fu_busy !== exp_busy)
		begin
			$display("Mismatch at %0t: row %0d fu_busy=%b, expected %b",
				$time, row, fu_busy, exp_busy);
			$display("SIMULATION FAILED");
			$fatal(1, "Busy check failed.");
		end
	endtask

	// Squash drops everything. Otherwise grant frees, done fills.
	task automatic update_model(input row_t row, input int idx);
		if (row.squash)
			m_full = NONE;
		else
		begin
			if (idx >= 0)
				m_full[idx] = 1'b0;
			for (int i = 0; i < `NUM_FU; i++)
			begin
				if (row.done[i])
				begin
					m_full[i] = 1'b1;
					m_res[i]  = res_in[i];
					m_tag[i]  = tag_in[i];
					m_rob[i]  = rob_in[i];
				end
			end
		end
		if (m_block > 0)
			m_block--; // Squash inside a flush does not restart it.
		else if (row.squash)
			m_block = `FLUSH_CYCLES;
	endtask

	initial
	begin
		int idx;
		rst_n   = 1'b0;
		squash  = 1'b0;
		done_in = NONE;
		for (int i = 0; i < `NUM_FU; i++)
		begin
			res_in[i] = '0;
			tag_in[i] = '0;
			rob_in[i] = '0;
		end
		seed    = 32'he082;
		m_full  = NONE;
		m_block = 0;
		load_table();

		repeat (10) @(posedge clk);
		#1 rst_n = 1'b1;

		for (int r = 0; r < NUM_ROWS; r++)
		begin
			@(posedge clk);
			#1;
			drive_row(rows[r]);
			if (m_block > 0 || rows[r].squash)
				idx = -1; // Bus blocked.
			else
				idx = top_slot(m_full);
			confirm_table_row(r, idx);
			#2; // Sample a nanosecond before the next edge.
			if (idx >= 0)
				check_bus(1'b1, m_tag[idx], m_res[idx], m_rob[idx], r);
			else
				check_bus(1'b0, '0, '0, '0, r);
			check_busy(m_full, r);
			update_model(rows[r], idx);
		end

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule
